// ==== common/cdi_loader_pkg.sv ====
package cdi_loader_pkg;

    // ============================================================
    // Address and data geometry
    // ============================================================

    // SDRAM is byte addressed, accessed as 16-bit words
    localparam int sdram_addr_w = 25;
    localparam int sdram_data_w = 16;

    // Boot ROM lives in the 001 region of SDRAM
    localparam logic [2:0] rom_region_prefix = 3'b001;

    // Index bit 6 set means slave firmware instead of main boot ROM
    localparam int slave_index_bit = 6;

    // Write-once memory of the slave controller
    localparam int worm_addr_w = 13;

    // Words cleared at the bottom of SDRAM before the core starts
    localparam int ram_zero_words = 64;

    // Top bit of the zero counter marks completion
    localparam int zero_cnt_w = $clog2(ram_zero_words) + 1;

    // ============================================================
    // Bundles
    // ============================================================

    // Host download stream
    typedef struct packed {
        logic                    download;
        logic                    wr;
        logic [sdram_addr_w-1:0] addr;
        logic [15:0]             dout;
        logic [15:0]             index;
    } ioctl_t;

    // One SDRAM request, request/busy handshake
    typedef struct packed {
        logic [sdram_addr_w-1:0] addr;
        logic [sdram_data_w-1:0] din;
        logic                    rd;
        logic                    wr;
        logic                    word;
        logic                    refresh;
        logic                    burst;
    } sdram_req_t;

    // Byte write into the slave's write-once memory
    typedef struct packed {
        logic [worm_addr_w-1:0] adr;
        logic [7:0]             data;
        logic                   wr;
    } worm_wr_t;

    // Who drives SDRAM during preparation, highest priority first
    typedef enum logic [1:0] {
        rom_download,
        ram_zero,
        refresh,
        idle
    } sdram_owner_e;

endpackage

// ==== loader/worm_byte_writer.sv ====
`timescale 1ns/100ps

module worm_byte_writer (
    input  logic                                   clk_sys,
    input  logic                                   rst_n,
    input  logic                                   slave_wr,
    input  logic [cdi_loader_pkg::worm_addr_w-1:0] word_addr,
    input  logic [cdi_loader_pkg::sdram_data_w-1:0] word_data,
    output cdi_loader_pkg::worm_wr_t               worm
);
    import cdi_loader_pkg::*;

    logic                   slave_wr_q;
    logic                   worm_wr;
    logic [worm_addr_w-1:0] worm_adr;
    logic [7:0]             worm_data;
    // Upper half waits here while the lower byte goes out
    logic [7:0]             high_byte;

    // Strobe and its delayed copy give a two-cycle write window
    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            slave_wr_q <= 1'b0;
            worm_wr    <= 1'b0;
        end else begin
            slave_wr_q <= slave_wr;
            worm_wr    <= slave_wr | slave_wr_q;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (slave_wr) begin
            // Low byte first, at the even address
            worm_adr  <= word_addr;
            worm_data <= word_data[7:0];
            high_byte <= word_data[15:8];
        end else begin
            worm_data   <= high_byte;
            worm_adr[0] <= 1'b1;
        end
    end

    assign worm = '{adr: worm_adr, data: worm_data, wr: worm_wr};

    // Second byte of a pair follows the first at the same address with bit 0 set
    a_second_byte_odd : assert property (
        @(posedge clk_sys) disable iff (!rst_n)
        (worm_wr && !slave_wr_q) |->
            ($past(worm_wr) && worm_adr == ($past(worm_adr) | worm_addr_w'(1)))
    );

endmodule

// ==== loader/download_router.sv ====
`timescale 1ns/100ps

module download_router (
    input  logic                                    clk_sys,
    input  logic                                    rst_n,
    input  cdi_loader_pkg::ioctl_t                  ioctl,
    input  logic                                    rom_done,
    output logic                                    rom_pending,
    output logic [cdi_loader_pkg::sdram_addr_w-1:0] rom_addr,
    output logic [cdi_loader_pkg::sdram_data_w-1:0] rom_data,
    output logic                                    download_start,
    output logic                                    ioctl_overflow,
    output cdi_loader_pkg::worm_wr_t                worm
);
    import cdi_loader_pkg::*;

    logic main_wr;
    logic slave_wr;
    logic download_q;

    // ============================================================
    // Stream split by index
    // ============================================================

    assign slave_wr = ioctl.wr & ioctl.index[slave_index_bit];
    assign main_wr  = ioctl.wr & ~ioctl.index[slave_index_bit];

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            rom_pending    <= 1'b0;
            ioctl_overflow <= 1'b0;
            download_q     <= 1'b0;
        end else begin
            download_q <= ioctl.download;
            // Host pushed a new word before the last one reached SDRAM
            if (main_wr && rom_pending)
                ioctl_overflow <= 1'b1;
            // A fresh word keeps the request alive even on a completion cycle
            if (main_wr)
                rom_pending <= 1'b1;
            else if (rom_done)
                rom_pending <= 1'b0;
        end
    end

    // Host is little endian, the 68k wants big endian words
    always_ff @(posedge clk_sys) begin
        if (main_wr) begin
            rom_addr <= {rom_region_prefix, ioctl.addr[sdram_addr_w-4:1], 1'b0};
            rom_data <= {ioctl.dout[7:0], ioctl.dout[15:8]};
        end
    end

    assign download_start = ioctl.download & ~download_q;

    // ============================================================
    // Slave firmware path
    // ============================================================

    worm_byte_writer u_worm_byte_writer (
        .clk_sys   (clk_sys),
        .rst_n     (rst_n),
        .slave_wr  (slave_wr),
        .word_addr (ioctl.addr[worm_addr_w-1:0]),
        .word_data (ioctl.dout),
        .worm      (worm)
    );

endmodule

// ==== logic/sdram_prep_arbiter.sv ====
`timescale 1ns/100ps

module sdram_prep_arbiter (
    input  logic                                    clk_sys,
    input  logic                                    rst_n,
    input  logic                                    user_reset,
    input  logic                                    download,
    input  logic                                    download_start,
    input  logic                                    rom_pending,
    input  logic [cdi_loader_pkg::sdram_addr_w-1:0] rom_addr,
    input  logic [cdi_loader_pkg::sdram_data_w-1:0] rom_data,
    input  cdi_loader_pkg::sdram_req_t              core_req,
    input  logic                                    sdram_busy,
    output cdi_loader_pkg::sdram_req_t              sdram_req,
    output logic                                    rom_done,
    output logic                                    core_reset
);
    import cdi_loader_pkg::*;

    sdram_owner_e            owner;
    sdram_owner_e            owner_q;
    sdram_owner_e            owner_next;
    logic                    sdram_busy_q;
    logic                    busy_fall;
    logic [zero_cnt_w-1:0]   zero_cnt;
    logic                    zero_done;
    logic [sdram_addr_w-1:0] zero_addr;
    sdram_req_t              prep_req;

    // ============================================================
    // Core reset and preparation window
    // ============================================================

    assign zero_done = (zero_cnt == zero_cnt_w'(ram_zero_words));

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n)
            core_reset <= 1'b1;
        else
            core_reset <= user_reset | download | ~zero_done;
    end

    // ============================================================
    // Owner selection
    // ============================================================

    always_comb begin
        owner_next = idle;
        if (core_reset) begin
            owner_next = refresh;
            if (!zero_done)
                owner_next = ram_zero;
            if (rom_pending)
                owner_next = rom_download;
        end
        // Keep the current owner until its access has finished
        owner = sdram_busy ? owner_q : owner_next;
    end

    assign busy_fall = sdram_busy_q & ~sdram_busy;
    assign rom_done  = busy_fall && (owner_q == rom_download);

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            owner_q      <= idle;
            // Reset counts as a busy cycle, so no write before the first edge
            sdram_busy_q <= 1'b1;
            zero_cnt     <= '0;
        end else begin
            owner_q      <= owner;
            sdram_busy_q <= sdram_busy;
            if (download_start)
                zero_cnt <= '0;
            else if (busy_fall && owner_q == ram_zero && !zero_done)
                zero_cnt <= zero_cnt + 1'b1;
        end
    end

    // ============================================================
    // Request generation
    // ============================================================

    // Word index to byte address
    assign zero_addr = sdram_addr_w'({zero_cnt[zero_cnt_w-2:0], 1'b0});

    always_comb begin
        prep_req      = '0;
        prep_req.word = 1'b1;
        prep_req.addr = zero_addr;
        case (owner)
            rom_download: begin
                prep_req.addr = rom_addr;
                prep_req.din  = rom_data;
                // Busy just fell, counters and pending flag settle first
                prep_req.wr   = ~sdram_busy_q;
            end
            ram_zero: begin
                prep_req.wr = ~sdram_busy_q;
            end
            refresh: begin
                prep_req.rd      = 1'b1;
                prep_req.refresh = 1'b1;
            end
            default: begin
            end
        endcase
        if (sdram_busy) begin
            prep_req.rd = 1'b0;
            prep_req.wr = 1'b0;
        end
    end

    // Core owns SDRAM once preparation is over
    assign sdram_req = core_reset ? prep_req : core_req;

    // ============================================================
    // Checks on the SDRAM port
    // ============================================================

    a_rd_wr_exclusive : assert property (
        @(posedge clk_sys) disable iff (!rst_n)
        !(sdram_req.rd && sdram_req.wr)
    );

    a_no_req_while_busy : assert property (
        @(posedge clk_sys) disable iff (!rst_n)
        sdram_busy |-> !(sdram_req.rd || sdram_req.wr)
    );

endmodule

// ==== logic/cdi_loader_top.sv ====
`timescale 1ns/100ps

module cdi_loader_top (
    input  logic                       clk_sys,
    input  logic                       rst_n,
    input  logic                       user_reset,
    input  cdi_loader_pkg::ioctl_t     ioctl,
    input  cdi_loader_pkg::sdram_req_t core_req,
    input  logic                       sdram_busy,
    output cdi_loader_pkg::sdram_req_t sdram_req,
    output logic                       core_reset,
    output cdi_loader_pkg::worm_wr_t   worm,
    output logic                       ioctl_overflow
);
    import cdi_loader_pkg::*;

    logic                    rom_pending;
    logic [sdram_addr_w-1:0] rom_addr;
    logic [sdram_data_w-1:0] rom_data;
    logic                    rom_done;
    logic                    download_start;

    download_router u_download_router (
        .clk_sys        (clk_sys),
        .rst_n          (rst_n),
        .ioctl          (ioctl),
        .rom_done       (rom_done),
        .rom_pending    (rom_pending),
        .rom_addr       (rom_addr),
        .rom_data       (rom_data),
        .download_start (download_start),
        .ioctl_overflow (ioctl_overflow),
        .worm           (worm)
    );

    sdram_prep_arbiter u_sdram_prep_arbiter (
        .clk_sys        (clk_sys),
        .rst_n          (rst_n),
        .user_reset     (user_reset),
        .download       (ioctl.download),
        .download_start (download_start),
        .rom_pending    (rom_pending),
        .rom_addr       (rom_addr),
        .rom_data       (rom_data),
        .core_req       (core_req),
        .sdram_busy     (sdram_busy),
        .sdram_req      (sdram_req),
        .rom_done       (rom_done),
        .core_reset     (core_reset)
    );

endmodule

// ==== tests/tb_sdram_responder.sv ====
`timescale 1ns/100ps

module tb_sdram_responder (
    input  logic                       clk_sys,
    input  logic                       rst_n,
    input  cdi_loader_pkg::sdram_req_t sdram_req,
    output logic                       sdram_busy
);
    import cdi_loader_pkg::*;

    localparam int log_depth = 256;

    integer seed;
    int     busy_left;
    int     wr_count;
    int     rd_count;
    int     refresh_count;

    // Stored words, keyed by byte address
    logic [sdram_data_w-1:0] mem [logic [sdram_addr_w-1:0]];

    // Accepted writes in arrival order
    logic [sdram_addr_w-1:0] wr_log_addr [log_depth];
    logic [sdram_data_w-1:0] wr_log_data [log_depth];
    logic                    wr_log_word [log_depth];

    initial seed = 46825;

    always @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            sdram_busy    <= 1'b0;
            busy_left     = 0;
            wr_count      = 0;
            rd_count      = 0;
            refresh_count = 0;
        end else if (sdram_busy) begin
            // Busy falls once the drawn access time has run out
            busy_left = busy_left - 1;
            if (busy_left == 0)
                sdram_busy <= 1'b0;
        end else if (sdram_req.rd || sdram_req.wr) begin
            sdram_busy <= 1'b1;
            busy_left  = 1 + ({$random(seed)} % 4);
            if (sdram_req.wr) begin
                mem[sdram_req.addr] = sdram_req.din;
                if (wr_count < log_depth) begin
                    wr_log_addr[wr_count] = sdram_req.addr;
                    wr_log_data[wr_count] = sdram_req.din;
                    wr_log_word[wr_count] = sdram_req.word;
                end
                wr_count = wr_count + 1;
            end else begin
                rd_count = rd_count + 1;
                if (sdram_req.refresh)
                    refresh_count = refresh_count + 1;
            end
        end
    end

endmodule

// ==== tests/tb_cdi_loader.sv ====
`timescale 1ns/100ps

module tb_cdi_loader;
    import cdi_loader_pkg::*;

    localparam int clk_period = 100;
    // Two worst-case zeroing passes of 64 words at 6 cycles each stay under 800 cycles,
    // the directed traffic around them under 200, so 2000 cycles leaves ample margin
    localparam int watchdog_cycles = 2000;

    logic       clk_sys;
    logic       rst_n;
    logic       user_reset;
    logic       sdram_busy;
    logic       core_reset;
    logic       ioctl_overflow;
    ioctl_t     ioctl;
    sdram_req_t core_req;
    sdram_req_t sdram_req;
    worm_wr_t   worm;
    int         error_count;

    cdi_loader_top dut (
        .clk_sys        (clk_sys),
        .rst_n          (rst_n),
        .user_reset     (user_reset),
        .ioctl          (ioctl),
        .core_req       (core_req),
        .sdram_busy     (sdram_busy),
        .sdram_req      (sdram_req),
        .core_reset     (core_reset),
        .worm           (worm),
        .ioctl_overflow (ioctl_overflow)
    );

    tb_sdram_responder responder (
        .clk_sys    (clk_sys),
        .rst_n      (rst_n),
        .sdram_req  (sdram_req),
        .sdram_busy (sdram_busy)
    );

    always #(clk_period / 2) clk_sys = ~clk_sys;

    initial begin
        #(watchdog_cycles * clk_period);
        $display("Watchdog expired after %0d cycles, the tests did not finish", watchdog_cycles);
        $display("Result: FAILED");
        $finish;
    end

    // ============================================================
    // Helpers
    // ============================================================

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
        error_count++;
    endtask

    task automatic report_problem(input string msg);
        $display("Error: %s", msg);
        error_count++;
    endtask

    task automatic wait_for_idle(input int limit);
        int n = 0;
        while (sdram_busy && n < limit) begin
            @(negedge clk_sys);
            n++;
        end
        if (sdram_busy)
            report_problem("SDRAM stayed busy longer than expected");
    endtask

    task automatic wait_for_writes(input int target, input int limit);
        int n = 0;
        while (responder.wr_count < target && n < limit) begin
            @(negedge clk_sys);
            n++;
        end
        if (responder.wr_count < target)
            report_problem("expected SDRAM writes never arrived");
    endtask

    task automatic wait_core_reset_low(input int limit);
        int n = 0;
        while (core_reset && n < limit) begin
            @(negedge clk_sys);
            n++;
        end
        if (core_reset)
            report_problem("core reset was never released");
    endtask

    // One full pass must clear words 0, 2, 4 and onward with full-word writes
    task automatic check_zero_pass(input int base);
        for (int i = 0; i < ram_zero_words; i++) begin
            if (responder.wr_log_addr[base + i] !== sdram_addr_w'(2 * i))
                report_mismatch("responder.wr_log_addr",
                                64'(responder.wr_log_addr[base + i]), 64'(2 * i));
            if (responder.wr_log_data[base + i] !== '0)
                report_mismatch("responder.wr_log_data",
                                64'(responder.wr_log_data[base + i]), 64'(0));
            if (responder.wr_log_word[base + i] !== 1'b1)
                report_mismatch("responder.wr_log_word",
                                64'(responder.wr_log_word[base + i]), 64'(1));
        end
    endtask

    // Called at a falling edge, holds the strobe for exactly one cycle
    task automatic strobe_word(input logic [sdram_addr_w-1:0] addr, input logic [15:0] data,
                               input logic [15:0] index);
        ioctl.addr  = addr;
        ioctl.dout  = data;
        ioctl.index = index;
        ioctl.wr    = 1'b1;
        @(negedge clk_sys);
        ioctl.wr = 1'b0;
    endtask

    // ============================================================
    // Directed tests
    // ============================================================

    task automatic zero_after_reset();
        @(negedge clk_sys);
        if (core_reset !== 1'b1)
            report_mismatch("core_reset", 64'(core_reset), 64'(1));
        if (worm.wr !== 1'b0)
            report_mismatch("worm.wr", 64'(worm.wr), 64'(0));
        if (ioctl_overflow !== 1'b0)
            report_mismatch("ioctl_overflow", 64'(ioctl_overflow), 64'(0));
        wait_core_reset_low(1000);
        if (responder.wr_count != ram_zero_words)
            report_mismatch("responder.wr_count", 64'(responder.wr_count),
                            64'(ram_zero_words));
        check_zero_pass(0);
    endtask

    task automatic refresh_during_download();
        int base = responder.wr_count;
        int refreshes;
        ioctl.download = 1'b1;
        // A new download starts a fresh zeroing pass first
        wait_for_writes(base + ram_zero_words, 1000);
        check_zero_pass(base);
        refreshes = responder.refresh_count;
        repeat (30) begin
            @(negedge clk_sys);
            if (sdram_req.wr)
                report_problem("SDRAM write issued while only refresh was due");
            if (sdram_req.rd && !sdram_req.refresh)
                report_problem("SDRAM read without the refresh flag during preparation");
            if (core_reset !== 1'b1)
                report_mismatch("core_reset", 64'(core_reset), 64'(1));
        end
        if (responder.wr_count != base + ram_zero_words)
            report_mismatch("responder.wr_count", 64'(responder.wr_count),
                            64'(base + ram_zero_words));
        if (responder.refresh_count == refreshes)
            report_problem("no refresh reads seen while the download was idle");
    endtask

    task automatic boot_rom_word();
        logic [sdram_addr_w-1:0] a;
        logic [15:0]             d;
        logic [sdram_addr_w-1:0] exp_addr;
        logic [15:0]             exp_data;
        int                      base;
        a = 25'h1F2_5679;
        d = 16'hBEEF;
        // Bits 24..22 become the ROM region, bits 21..1 stay, bit 0 is dropped
        exp_addr = (a & 25'h03F_FFFE) | (25'(rom_region_prefix) << 22);
        exp_data = (d << 8) | (d >> 8);
        base = responder.wr_count;
        strobe_word(a, d, 16'h0000);
        wait_for_writes(base + 1, 50);
        wait_for_idle(10);
        repeat (3) @(negedge clk_sys);
        if (responder.wr_count != base + 1)
            report_mismatch("responder.wr_count", 64'(responder.wr_count), 64'(base + 1));
        if (responder.wr_log_addr[base] !== exp_addr)
            report_mismatch("sdram_req.addr", 64'(responder.wr_log_addr[base]), 64'(exp_addr));
        if (responder.wr_log_word[base] !== 1'b1)
            report_mismatch("sdram_req.word", 64'(responder.wr_log_word[base]), 64'(1));
        if (responder.mem[exp_addr] !== exp_data)
            report_mismatch("responder.mem", 64'(responder.mem[exp_addr]), 64'(exp_data));
    endtask

    task automatic slave_firmware_word();
        logic [worm_addr_w-1:0] w;
        logic [15:0]            d;
        int                     base;
        w = 13'h0A4;
        d = 16'h5AC3;
        base = responder.wr_count;
        strobe_word(25'(w), d, 16'(1) << slave_index_bit);
        if (worm.wr !== 1'b1 || worm.adr !== w || worm.data !== d[7:0])
            report_mismatch("worm first byte", 64'(worm), 64'({w, d[7:0], 1'b1}));
        @(negedge clk_sys);
        if (worm.wr !== 1'b1 || worm.adr !== (w | 13'h1) || worm.data !== d[15:8])
            report_mismatch("worm second byte", 64'(worm), 64'({w | 13'h1, d[15:8], 1'b1}));
        @(negedge clk_sys);
        if (worm.wr !== 1'b0)
            report_mismatch("worm.wr", 64'(worm.wr), 64'(0));
        repeat (3) @(negedge clk_sys);
        if (responder.wr_count != base)
            report_problem("slave firmware word caused an SDRAM write");
    endtask

    task automatic overflow_on_back_to_back();
        if (ioctl_overflow !== 1'b0)
            report_mismatch("ioctl_overflow", 64'(ioctl_overflow), 64'(0));
        strobe_word(25'h000_0100, 16'h1111, 16'h0000);
        strobe_word(25'h000_0102, 16'h2222, 16'h0000);
        if (ioctl_overflow !== 1'b1)
            report_mismatch("ioctl_overflow", 64'(ioctl_overflow), 64'(1));
        repeat (20) @(negedge clk_sys);
        // Sticky until the next reset
        if (ioctl_overflow !== 1'b1)
            report_mismatch("ioctl_overflow", 64'(ioctl_overflow), 64'(1));
        wait_for_idle(10);
    endtask

    task automatic core_passthrough();
        sdram_req_t req;
        int         rd_base;
        ioctl.download = 1'b0;
        wait_core_reset_low(20);
        wait_for_idle(10);
        rd_base = responder.rd_count;
        req = '0;
        req.addr  = 25'h012_3456;
        req.rd    = 1'b1;
        req.word  = 1'b1;
        req.burst = 1'b1;
        core_req = req;
        #(clk_period / 4);
        if (sdram_req !== req)
            report_mismatch("sdram_req read", 64'(sdram_req), 64'(req));
        @(negedge clk_sys);
        core_req = '0;
        wait_for_idle(10);
        if (responder.rd_count != rd_base + 1)
            report_mismatch("responder.rd_count", 64'(responder.rd_count), 64'(rd_base + 1));
        req = '0;
        req.addr = 25'h000_0200;
        req.din  = 16'hC0DE;
        req.wr   = 1'b1;
        req.word = 1'b1;
        core_req = req;
        #(clk_period / 4);
        if (sdram_req !== req)
            report_mismatch("sdram_req write", 64'(sdram_req), 64'(req));
        @(negedge clk_sys);
        core_req = '0;
        wait_for_idle(10);
        if (responder.mem[25'h000_0200] !== 16'hC0DE)
            report_mismatch("responder.mem", 64'(responder.mem[25'h000_0200]), 64'(16'hC0DE));
    endtask

    // ============================================================
    // Sequence
    // ============================================================

    initial begin
        clk_sys     = 1'b0;
        rst_n       = 1'b0;
        user_reset  = 1'b0;
        ioctl       = '0;
        core_req    = '0;
        error_count = 0;
        repeat (5) @(negedge clk_sys);
        if (sdram_req.rd || sdram_req.wr)
            report_problem("SDRAM request issued during reset");
        rst_n = 1'b1;

        zero_after_reset();
        refresh_during_download();
        boot_rom_word();
        slave_firmware_word();
        overflow_on_back_to_back();
        core_passthrough();

        $display("Tests finished with %0d errors", error_count);
        if (error_count == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

// ==== flist.f ====
common/cdi_loader_pkg.sv
loader/worm_byte_writer.sv
loader/download_router.sv
logic/sdram_prep_arbiter.sv
logic/cdi_loader_top.sv
tests/tb_sdram_responder.sv
tests/tb_cdi_loader.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the loader testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module tb_cdi_loader -f flist.f -o tb_cdi_loader
./obj_dir/tb_cdi_loader | tee sim.log

if grep -q "^Result: PASSED$" sim.log; then
    echo "Simulation passed"
    exit 0
fi
echo "Simulation failed"
exit 1
